//--- bomb/bomb_timer.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module bomb_timer
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tick,
  input  bomb_pkg::bomb_req_t     bomb_req,
  output logic                    armed,
  output logic [`ADDR_WIDTH-1:0]  bomb_addr,
  output logic                    explode
);

  // Fuse counter covers 0 to EXPLODE_TICKS-1
  localparam int CNT_W = $clog2(`EXPLODE_TICKS + 1);
  localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(`EXPLODE_TICKS - 1);

  logic [CNT_W-1:0] tick_cnt;   // Ticks seen since arming
  logic             accept;     // New bomb taken this cycle
  logic             fuse_out;   // Current tick ends the fuse

  assign accept   = bomb_req.drop && !armed;            // Only one live bomb
  assign fuse_out = armed && tick && (tick_cnt == LAST_TICK);

  // ----------------------------------------------------------------------
  // Armed flag, fuse counter and explode pulse
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      armed    <= 1'b0;
      explode  <= 1'b0;
      tick_cnt <= '0;
    end
    else
    begin
      explode <= 1'b0;                // Pulse lasts one cycle
      if (accept)
      begin
        armed    <= 1'b1;
        tick_cnt <= '0;               // Fresh fuse
      end
      else if (fuse_out)
      begin
        armed    <= 1'b0;             // Cleared together with the pulse
        explode  <= 1'b1;
        tick_cnt <= '0;
      end
      else if (armed && tick)
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Bomb position
  // ----------------------------------------------------------------------
  // Kept after the pulse so the explosion FSM can still read it
  always_ff @(posedge clk)
  begin
    if (accept)
      bomb_addr <= bomb_req.addr;     // Drops while armed never reach here
  end

endmodule

//--- bomb/free_blocks.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module free_blocks
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    explode,
  input  logic [`ADDR_WIDTH-1:0]  explosion_addr,
  output logic [`ADDR_WIDTH-1:0]  map_rd_addr,
  input  bomb_pkg::tile_t         map_rd_data,
  output bomb_pkg::map_wr_t       map_wr
);

  import bomb_pkg::*;

  localparam int AW = `ADDR_WIDTH;
  localparam logic [AW-1:0] COL_STEP = AW'(`NUM_COL);   // One row up or down

  // Neighbor order, one per direction count
  localparam logic [1:0] DIR_UP    = 2'd0;
  localparam logic [1:0] DIR_DOWN  = 2'd1;
  localparam logic [1:0] DIR_LEFT  = 2'd2;
  localparam logic [1:0] DIR_RIGHT = 2'd3;

  // ----------------------------------------------------------------------
  // Explosion FSM
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] { IDLE, CHECK_BLKS, FREE_BLKS } state_t;

  state_t          state, state_nxt;
  logic [1:0]      dir_cnt;      // Neighbor being read or written
  logic [1:0]      dir_lag;      // Neighbor whose read data is back
  logic            rd_pend;      // Read data valid this cycle
  logic [3:0]      mark;         // Neighbors to clear, one bit per direction
  logic [AW-1:0]   saved_addr;   // Bomb tile for the whole explosion
  logic [AW-1:0]   base_addr;
  logic [AW-1:0]   nbr_addr;
  logic            check_done;
  logic            free_done;

  assign check_done = (state == CHECK_BLKS) && (dir_cnt == DIR_RIGHT);
  assign free_done  = (state == FREE_BLKS) && (dir_cnt == DIR_RIGHT);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;            // Hold by default
    case (state)
      IDLE:       if (explode) state_nxt = CHECK_BLKS;
      CHECK_BLKS: if (check_done) state_nxt = FREE_BLKS;
      FREE_BLKS:  if (free_done) state_nxt = IDLE;
      default:    state_nxt = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Direction counters and mark bits
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dir_cnt <= '0;
      dir_lag <= '0;
      rd_pend <= 1'b0;
      mark    <= '0;
    end
    else
    begin
      rd_pend <= 1'b0;
      case (state)
        IDLE:
        begin
          if (explode)
          begin
            dir_cnt <= dir_cnt + 1'b1;    // UP read goes out this cycle
            dir_lag <= dir_cnt;
            rd_pend <= 1'b1;
            mark    <= '0;                // Forget the last explosion
          end
          else
            dir_cnt <= '0;
        end
        CHECK_BLKS:
        begin
          dir_cnt <= dir_cnt + 1'b1;      // Wraps to UP for the write pass
          dir_lag <= dir_cnt;
          rd_pend <= 1'b1;
        end
        FREE_BLKS: dir_cnt <= dir_cnt + 1'b1;
        default:   dir_cnt <= '0;
      endcase
      // RIGHT data lands in the first FREE_BLKS cycle
      if (rd_pend && (map_rd_data == DESTROY_BLK))
        mark[dir_lag] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && explode)
      saved_addr <= explosion_addr;
  end

  // ----------------------------------------------------------------------
  // Neighbor address, shared by reads and writes
  // ----------------------------------------------------------------------
  always_comb
  begin
    // First read uses the live address, the latch is not loaded yet
    base_addr = (state == IDLE) ? explosion_addr : saved_addr;
    case (dir_cnt)
      DIR_UP:   nbr_addr = base_addr - COL_STEP;
      DIR_DOWN: nbr_addr = base_addr + COL_STEP;
      DIR_LEFT: nbr_addr = base_addr - 1'b1;
      default:  nbr_addr = base_addr + 1'b1;   // Right
    endcase
  end

  assign map_rd_addr  = nbr_addr;
  assign map_wr.wr_en = (state == FREE_BLKS) && mark[dir_cnt];
  assign map_wr.addr  = nbr_addr;
  assign map_wr.tile  = NO_BLK;     // Destroyed blocks become floor

endmodule

//--- common/bomb_defines.svh
`ifndef BOMB_DEFINES_SVH
`define BOMB_DEFINES_SVH

// ----------------------------------------------------------------------
// Map geometry in tiles
// ----------------------------------------------------------------------
`define NUM_ROW 11                          // Rows, one word each
`define NUM_COL 19                          // Columns, row stride in the memory
`define MAP_DEPTH (`NUM_ROW * `NUM_COL)     // Tile count
`define ADDR_WIDTH $clog2(`MAP_DEPTH)       // Tile address width

// ----------------------------------------------------------------------
// Pixel geometry
// ----------------------------------------------------------------------
`define TILE_PX 64                          // Tile edge in pixels
`define TILE_SHIFT $clog2(`TILE_PX)         // Pixel to tile shift
`define SPRITE_W 32                         // Sprite box width
`define SPRITE_H 48                         // Sprite box height
`define PIX_WIDTH 11                        // Pixel coordinate width

// Fuse length in game ticks
`define EXPLODE_TICKS 3

`endif

//--- common/bomb_pkg.sv
`include "bomb_defines.svh"

package bomb_pkg;

  // ----------------------------------------------------------------------
  // Tile contents, two bits per map word
  // ----------------------------------------------------------------------
  // Code 3 is reserved and never written
  typedef enum logic [1:0]
  {
    NO_BLK      = 2'd0,  // Free floor
    SOLID_BLK   = 2'd1,  // Pillar or border
    DESTROY_BLK = 2'd2   // Cleared by an explosion
  } tile_t;

  // Bomb drop request from the locator
  typedef struct packed
  {
    logic                     drop;  // One-cycle strobe
    logic [`ADDR_WIDTH-1:0]   addr;  // Tile under the sprite's feet
  } bomb_req_t;

  // ----------------------------------------------------------------------
  // Map write port
  // ----------------------------------------------------------------------
  typedef struct packed
  {
    logic                     wr_en; // Write strobe
    logic [`ADDR_WIDTH-1:0]   addr;  // Target tile
    tile_t                    tile;  // New contents
  } map_wr_t;

endpackage

//--- filelist.f
+incdir+common
common/bomb_pkg.sv
hdl/tile_locator.sv
bomb/bomb_timer.sv
bomb/free_blocks.sv
hdl/tile_map.sv
hdl/bomb_top.sv
tb/bomb_tb.sv

//--- hdl/bomb_top.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module bomb_top
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tick,        // Game clock divider pulse
  input  logic                    drop,        // Player drops a bomb
  input  logic [`PIX_WIDTH-1:0]   sprite_x,
  input  logic [`PIX_WIDTH-1:0]   sprite_y,
  input  logic [`ADDR_WIDTH-1:0]  query_addr,
  output bomb_pkg::tile_t         query_tile,
  output logic                    armed,
  output logic [`ADDR_WIDTH-1:0]  bomb_addr
);

  import bomb_pkg::*;

  // ----------------------------------------------------------------------
  // Stage to stage wires
  // ----------------------------------------------------------------------
  bomb_req_t               bomb_req;      // Locator to timer
  logic                    explode;       // Fuse ran out
  logic [`ADDR_WIDTH-1:0]  expl_rd_addr;  // Neighbor read
  tile_t                   expl_rd_data;
  map_wr_t                 map_wr;        // Block clear

  // Decode
  tile_locator i_tile_locator
  (
    .clk      (clk),
    .rst      (rst),
    .drop     (drop),
    .sprite_x (sprite_x),
    .sprite_y (sprite_y),
    .bomb_req (bomb_req)
  );

  // Execute
  bomb_timer i_bomb_timer
  (
    .clk       (clk),
    .rst       (rst),
    .tick      (tick),
    .bomb_req  (bomb_req),
    .armed     (armed),
    .bomb_addr (bomb_addr),
    .explode   (explode)
  );

  free_blocks i_free_blocks
  (
    .clk            (clk),
    .rst            (rst),
    .explode        (explode),
    .explosion_addr (bomb_addr),    // Still held after armed drops
    .map_rd_addr    (expl_rd_addr),
    .map_rd_data    (expl_rd_data),
    .map_wr         (map_wr)
  );

  // Result
  tile_map i_tile_map
  (
    .clk          (clk),
    .rst          (rst),
    .map_wr       (map_wr),
    .expl_rd_addr (expl_rd_addr),
    .expl_rd_data (expl_rd_data),
    .query_addr   (query_addr),
    .query_tile   (query_tile)
  );

endmodule

//--- hdl/tile_locator.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module tile_locator
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    drop,
  input  logic [`PIX_WIDTH-1:0]   sprite_x,
  input  logic [`PIX_WIDTH-1:0]   sprite_y,
  output bomb_pkg::bomb_req_t     bomb_req
);

  localparam int AW    = `ADDR_WIDTH;
  localparam int POS_W = `PIX_WIDTH + 1;             // One spare bit for the offset
  localparam int TPOS_W = POS_W - `TILE_SHIFT;       // Tile coordinate width

  // ----------------------------------------------------------------------
  // Foot center of the sprite box
  // ----------------------------------------------------------------------
  logic [POS_W-1:0]  foot_x;      // Horizontal center
  logic [POS_W-1:0]  foot_y;      // Bottom pixel row
  logic [TPOS_W-1:0] tile_col;
  logic [TPOS_W-1:0] tile_row;
  logic [AW-1:0]     tile_addr;

  always_comb
  begin
    foot_x = POS_W'(sprite_x) + POS_W'(`SPRITE_W / 2);
    foot_y = POS_W'(sprite_y) + POS_W'(`SPRITE_H - 1);
    // Drop the pixel offset inside the tile
    tile_col = TPOS_W'(foot_x >> `TILE_SHIFT);
    tile_row = TPOS_W'(foot_y >> `TILE_SHIFT);
    // Row major, NUM_COL words per row
    tile_addr = AW'(tile_row * `NUM_COL + tile_col);
  end

  // ----------------------------------------------------------------------
  // Request register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (drop)
      bomb_req.addr <= tile_addr;   // Held until the next drop
    if (rst)
      bomb_req.drop <= 1'b0;
    else
      bomb_req.drop <= drop;        // Strobe delayed one cycle with its address
  end

endmodule

//--- hdl/tile_map.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module tile_map
(
  input  logic                    clk,
  input  logic                    rst,
  input  bomb_pkg::map_wr_t       map_wr,
  input  logic [`ADDR_WIDTH-1:0]  expl_rd_addr,
  output bomb_pkg::tile_t         expl_rd_data,
  input  logic [`ADDR_WIDTH-1:0]  query_addr,
  output bomb_pkg::tile_t         query_tile
);

  import bomb_pkg::*;

  localparam int AW    = `ADDR_WIDTH;
  localparam int ROW_W = $clog2(`NUM_ROW);
  localparam int COL_W = $clog2(`NUM_COL);

  tile_t mem [`MAP_DEPTH];          // One word per tile, row major

  // ----------------------------------------------------------------------
  // Layout fill after reset
  // ----------------------------------------------------------------------
  logic             filling;        // Fill pass still running
  logic [ROW_W-1:0] fill_row;
  logic [COL_W-1:0] fill_col;
  logic [AW-1:0]    fill_addr;      // Tracks row * NUM_COL + col
  logic [COL_W:0]   diag_sum;       // Row plus column
  tile_t            fill_tile;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      filling   <= 1'b1;
      fill_row  <= '0;
      fill_col  <= '0;
      fill_addr <= '0;
    end
    else if (filling)
    begin
      fill_addr <= fill_addr + 1'b1;
      if (fill_addr == AW'(`MAP_DEPTH - 1))
        filling <= 1'b0;                          // Last tile written
      if (fill_col == COL_W'(`NUM_COL - 1))
      begin
        fill_col <= '0;
        fill_row <= fill_row + 1'b1;
      end
      else
        fill_col <= fill_col + 1'b1;
    end
  end

  always_comb
  begin
    diag_sum = (COL_W + 1)'(fill_row) + (COL_W + 1)'(fill_col);
    if ((fill_row == '0) || (fill_row == ROW_W'(`NUM_ROW - 1)) ||
        (fill_col == '0) || (fill_col == COL_W'(`NUM_COL - 1)))
      fill_tile = SOLID_BLK;                      // Closed border
    else if (!fill_row[0] && !fill_col[0])
      fill_tile = SOLID_BLK;                      // Pillar grid
    else if ((diag_sum % 3) == 0)
      fill_tile = NO_BLK;
    else
      fill_tile = DESTROY_BLK;
  end

  // ----------------------------------------------------------------------
  // Write port, fill first
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (filling)
      mem[fill_addr] <= fill_tile;
    else if (map_wr.wr_en)
      mem[map_wr.addr] <= map_wr.tile;
  end

  // Registered reads, old data on a same-edge write
  always_ff @(posedge clk)
  begin
    expl_rd_data <= mem[expl_rd_addr];
    query_tile   <= mem[query_addr];              // Renderer side
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bomb testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
( verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module bomb_tb \
    -o bomb_sim && ./obj_dir/bomb_sim ) 2>&1 | tee sim.log
grep -q "TESTBENCH PASSED" sim.log && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

//--- tb/bomb_tb.sv
`timescale 1ns/1ps
`include "bomb_defines.svh"

module bomb_tb;

  import bomb_pkg::*;

  localparam int AW = `ADDR_WIDTH;
  localparam int PW = `PIX_WIDTH;
  localparam int NUM_DROPS = 22;                        // Two directed and 20 random
  localparam int DROP_BUDGET = 2 * `EXPLODE_TICKS + 20 + `MAP_DEPTH;  // Drop plus fuse plus sweep
  localparam int CYCLE_LIMIT = 16 + 2 * `MAP_DEPTH + NUM_DROPS * DROP_BUDGET + 200;

  logic clk = 1'b0;
  logic rst, tick, drop;
  logic [PW-1:0] sprite_x, sprite_y;
  logic [AW-1:0] query_addr, bomb_addr;
  tile_t query_tile;
  logic armed;

  // Check strobes set 1 ns after an edge and sampled at the next one
  logic cmp_on, arm_on, addr_on, arm_exp;
  tile_t cmp_exp;
  logic [AW-1:0] cmp_addr, addr_exp;
  string test_name;
  tile_t model [`MAP_DEPTH];       // Reference map
  int unsigned lcg_state = 99387;
  int cycle_cnt = 0;
  int center;

  always #4 clk = ~clk;            // 8 ns period

  bomb_top i_bomb_top (.clk(clk), .rst(rst), .tick(tick), .drop(drop), .sprite_x(sprite_x),
    .sprite_y(sprite_y), .query_addr(query_addr), .query_tile(query_tile), .armed(armed),
    .bomb_addr(bomb_addr));

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  map_check: assert property (@(posedge clk) cmp_on |-> (query_tile == cmp_exp))
  else
  begin
    $display("ERROR %s: tile %0d expected %0d actual %0d", test_name, $sampled(cmp_addr),
             $sampled(cmp_exp), $sampled(query_tile));
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  armed_check: assert property (@(posedge clk) arm_on |-> (armed == arm_exp))
  else
  begin
    $display("ERROR %s: armed expected %0d actual %0d", test_name, $sampled(arm_exp),
             $sampled(armed));
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  addr_check: assert property (@(posedge clk) addr_on |-> (bomb_addr == addr_exp))
  else
  begin
    $display("ERROR %s: bomb_addr expected %0d actual %0d", test_name, $sampled(addr_exp),
             $sampled(bomb_addr));
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------------------
  // Model and stimulus helpers
  // ----------------------------------------------------------------------
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;         // Upper bits of the state
  endfunction

  function automatic tile_t initial_tile(input int row, input int col);
    if (row == 0 || row == `NUM_ROW - 1 || col == 0 || col == `NUM_COL - 1)
      return SOLID_BLK;            // Border
    if (row % 2 == 0 && col % 2 == 0)
      return SOLID_BLK;            // Pillars
    if ((row + col) % 3 == 0)
      return NO_BLK;
    return DESTROY_BLK;
  endfunction

  // Tile under the foot center of the sprite
  function automatic int foot_addr(input int x, input int y);
    return ((y + `SPRITE_H - 1) / `TILE_PX) * `NUM_COL + (x + `SPRITE_W / 2) / `TILE_PX;
  endfunction

  task automatic apply_explosion(input int addr);
    int nbr [4];
    nbr = '{addr - `NUM_COL, addr + `NUM_COL, addr - 1, addr + 1};
    foreach (nbr[i])
      if (model[nbr[i]] == DESTROY_BLK)
        model[nbr[i]] = NO_BLK;    // Already free or solid stays
  endtask

  task automatic expect_armed(input logic exp);
    arm_exp = exp;
    arm_on = 1'b1;
    @(posedge clk);
    #1;
    arm_on = 1'b0;
  endtask

  task automatic expect_addr(input int exp);
    addr_exp = AW'(exp);
    addr_on = 1'b1;
    @(posedge clk);
    #1;
    addr_on = 1'b0;
  endtask

  // Tile read back one cycle after its address goes out
  task automatic sweep_map();
    for (int a = 0; a <= `MAP_DEPTH; a++)
    begin
      @(posedge clk);
      #1;
      cmp_on = (a > 0);
      cmp_addr = AW'(a - 1);
      cmp_exp = (a > 0) ? model[a - 1] : NO_BLK;
      if (a < `MAP_DEPTH)
        query_addr = AW'(a);
    end
    @(posedge clk);
    #1;
    cmp_on = 1'b0;
  endtask

  task automatic drop_bomb(input int x, input int y, input bit fresh);
    sprite_x = PW'(x);
    sprite_y = PW'(y);
    drop = 1'b1;
    @(posedge clk);
    #1;
    drop = 1'b0;
    if (fresh)
      expect_armed(1'b0);          // Request still in the locator register
    else
    begin
      @(posedge clk);
      #1;
    end
    expect_armed(1'b1);
  endtask

  task automatic fire_bomb();
    for (int t = 0; t < `EXPLODE_TICKS; t++)
    begin
      tick = 1'b1;
      @(posedge clk);
      #1;
      tick = 1'b0;
      if (t < `EXPLODE_TICKS - 1)
        expect_armed(1'b1);        // Fuse still burning
      else
        expect_armed(1'b0);        // Dropped together with the explode pulse
    end
    repeat (9) @(posedge clk);     // 10 cycles past the firing tick
    #1;
    expect_armed(1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    int x;
    int y;
    rst = 1'b1;
    tick = 1'b0;
    drop = 1'b0;
    sprite_x = '0;
    sprite_y = '0;
    query_addr = '0;
    {cmp_on, arm_on, addr_on, arm_exp} = '0;
    cmp_exp = NO_BLK;
    cmp_addr = '0;
    addr_exp = '0;
    for (int a = 0; a < `MAP_DEPTH; a++)
      model[a] = initial_tile(a / `NUM_COL, a % `NUM_COL);
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (`MAP_DEPTH + 2) @(posedge clk);  // Fill runs on after reset
    #1;

    test_name = "initial_map";
    expect_armed(1'b0);
    sweep_map();

    test_name = "locator";
    center = foot_addr(200, 180);  // Row 3 column 3 with four destroyable neighbors
    drop_bomb(200, 180, 1'b1);
    expect_addr(center);

    test_name = "ignored_drop";
    drop_bomb(600, 400, 1'b0);
    expect_addr(center);

    test_name = "explosion";
    fire_bomb();
    apply_explosion(center);
    sweep_map();

    test_name = "random_drops";
    for (int i = 0; i < 20; i++)
    begin
      x = 48 + int'(next_rand() % 1088);  // Columns 1 to NUM_COL-2
      y = 17 + int'(next_rand() % 576);   // Rows 1 to NUM_ROW-2
      center = foot_addr(x, y);
      drop_bomb(x, y, 1'b1);
      expect_addr(center);
      fire_bomb();
      apply_explosion(center);
      sweep_map();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
